// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic types.
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    typedef enum logic [2:0] {
        st_if  = 3'd0,
        st_id  = 3'd1,
        st_exe = 3'd2,
        st_mem = 3'd3,
        st_wb  = 3'd4
    } cpu_state_e;

    localparam word_t     reset_pc = 32'h1c00_0000;
    localparam reg_addr_t link_reg = 5'd1;

    // one-hot alu select bit positions.
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    ////////////////////////////////////////////////////////////////////////////
    // opcode fields.
    ////////////////////////////////////////////////////////////////////////////

    // 3r and shift forms, matched on inst[31:15].
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // 2ri12 forms, matched on inst[31:22].
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // branch forms, matched on inst[31:26].
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

    // 1ri20 form, matched on inst[31:25].
    localparam logic [6:0] op_lu12i_w = 7'h0a;

endpackage

// ==== core/decoder.sv ====
module decoder
    import cpu_pkg::*;
(
    input  word_t     inst,
    input  word_t     pc,
    output alu_op_t   alu_op,
    output reg_addr_t rj,
    output reg_addr_t rkd,
    output reg_addr_t dest,
    output word_t     imm,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      is_load,
    output logic      is_store,
    output logic      is_beq,
    output logic      is_bne,
    output logic      is_jump,
    output logic      gr_we,
    output word_t     br_target_pc,
    output word_t     jirl_offs
);

    reg_addr_t   rd;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    word_t       br_offs;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic inst_valid;
    logic need_ui5, need_si20, need_si26, src2_is_4;

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    ////////////////////////////////////////////////////////////////////////////
    // opcode match.
    ////////////////////////////////////////////////////////////////////////////

    assign inst_add_w   = inst[31:15] == op_add_w;
    assign inst_sub_w   = inst[31:15] == op_sub_w;
    assign inst_slt     = inst[31:15] == op_slt;
    assign inst_sltu    = inst[31:15] == op_sltu;
    assign inst_nor     = inst[31:15] == op_nor;
    assign inst_and     = inst[31:15] == op_and;
    assign inst_or      = inst[31:15] == op_or;
    assign inst_xor     = inst[31:15] == op_xor;
    assign inst_slli_w  = inst[31:15] == op_slli_w;
    assign inst_srli_w  = inst[31:15] == op_srli_w;
    assign inst_srai_w  = inst[31:15] == op_srai_w;
    assign inst_addi_w  = inst[31:22] == op_addi_w;
    assign inst_ld_w    = inst[31:22] == op_ld_w;
    assign inst_st_w    = inst[31:22] == op_st_w;
    assign inst_jirl    = inst[31:26] == op_jirl;
    assign inst_b       = inst[31:26] == op_b;
    assign inst_bl      = inst[31:26] == op_bl;
    assign inst_beq     = inst[31:26] == op_beq;
    assign inst_bne     = inst[31:26] == op_bne;
    assign inst_lu12i_w = inst[31:25] == op_lu12i_w;

    assign inst_valid = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                      | inst_nor | inst_and | inst_or | inst_xor
                      | inst_slli_w | inst_srli_w | inst_srai_w
                      | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                      | inst_jirl | inst_b | inst_bl | inst_beq | inst_bne;

    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                            | inst_jirl | inst_bl;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt;
    assign alu_op[alu_sltu] = inst_sltu;
    assign alu_op[alu_and]  = inst_and;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or;
    assign alu_op[alu_xor]  = inst_xor;
    assign alu_op[alu_sll]  = inst_slli_w;
    assign alu_op[alu_srl]  = inst_srli_w;
    assign alu_op[alu_sra]  = inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    ////////////////////////////////////////////////////////////////////////////
    // immediates and operand routing.
    ////////////////////////////////////////////////////////////////////////////

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    // link value is pc + 4.
    assign src2_is_4 = inst_jirl | inst_bl;

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {i20, 12'd0} :
                 need_ui5  ? {27'd0, rk} :
                             {{20{i12[11]}}, i12};

    assign br_offs   = need_si26 ? {{4{i26[25]}}, i26, 2'b00} : {{14{i16[15]}}, i16, 2'b00};
    assign jirl_offs = {{14{i16[15]}}, i16, 2'b00};

    assign br_target_pc = pc + br_offs;

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                       | src2_is_4;

    assign rkd  = (inst_st_w | inst_beq | inst_bne) ? rd : rk;
    assign dest = inst_bl ? link_reg : rd;

    assign is_load  = inst_ld_w;
    assign is_store = inst_st_w;
    assign is_beq   = inst_beq;
    assign is_bne   = inst_bne;
    assign is_jump  = inst_jirl | inst_b | inst_bl;
    assign gr_we    = inst_valid & ~(inst_st_w | inst_beq | inst_bne | inst_b);

endmodule

// ==== core/mycpu_top.sv ====
module mycpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // instruction sram.
    output word_t     inst_sram_addr,
    input  word_t     inst_sram_rdata,
    // data sram.
    output logic      data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  word_t     data_sram_rdata,
    // writeback trace.
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    cpu_state_e state;
    cpu_state_e state_next;

    word_t pc;
    word_t next_pc;
    word_t inst_r;
    word_t inst_word;
    word_t rj_val;
    word_t rkd_val;
    word_t alu_r;
    word_t load_r;

    alu_op_t   alu_op;
    reg_addr_t rj;
    reg_addr_t rkd;
    reg_addr_t dest;
    word_t     imm;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      is_load;
    logic      is_store;
    logic      is_beq;
    logic      is_bne;
    logic      is_jump;
    logic      gr_we;
    word_t     br_target_pc;
    word_t     jirl_offs;

    word_t rf_rdata1;
    word_t rf_rdata2;
    logic  rf_we;
    word_t wb_data;
    word_t alu_src1;
    word_t alu_src2;
    word_t alu_result;

    logic  is_jirl;
    logic  br_only;
    logic  br_taken;
    word_t br_target;
    word_t npc;

    // the fetched word is only on the sram bus during id.
    assign inst_word = (state == st_id) ? inst_sram_rdata : inst_r;

    decoder u_decoder (
        .inst         (inst_word),
        .pc           (pc),
        .alu_op       (alu_op),
        .rj           (rj),
        .rkd          (rkd),
        .dest         (dest),
        .imm          (imm),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jump      (is_jump),
        .gr_we        (gr_we),
        .br_target_pc (br_target_pc),
        .jirl_offs    (jirl_offs)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rkd),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (wb_data)
    );

    assign alu_src1 = src1_is_pc ? pc : rj_val;
    assign alu_src2 = src2_is_imm ? imm : rkd_val;

    alu u_alu (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // branch resolution in id.
    ////////////////////////////////////////////////////////////////////////////

    // jirl is the only register-indirect jump.
    assign is_jirl = is_jump & (inst_word[31:26] == op_jirl);
    // b, beq and bne finish in id.
    assign br_only = is_beq | is_bne | (is_jump & ~gr_we);

    assign br_taken  = (is_beq & (rf_rdata1 == rf_rdata2))
                     | (is_bne & (rf_rdata1 != rf_rdata2))
                     | is_jump;
    assign br_target = is_jirl ? rf_rdata1 + jirl_offs : br_target_pc;
    assign npc       = br_taken ? br_target : pc + 32'd4;

    always_comb begin
        case (state)
            st_if:   state_next = st_id;
            st_id:   state_next = br_only ? st_if : st_exe;
            st_exe:  state_next = (is_load | is_store) ? st_mem : st_wb;
            st_mem:  state_next = is_load ? st_wb : st_if;
            default: state_next = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_if;
            pc    <= reset_pc;
        end else begin
            state <= state_next;
            if (state == st_id && br_only) begin
                pc <= npc;
            end else if (state != st_if && state_next == st_if) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_id) begin
            inst_r  <= inst_sram_rdata;
            rj_val  <= rf_rdata1;
            rkd_val <= rf_rdata2;
            next_pc <= npc;
        end
        if (state == st_exe) begin
            alu_r <= alu_result;
        end
        if (state == st_mem) begin
            load_r <= data_sram_rdata;
        end
    end

    assign inst_sram_addr = pc;

    assign data_sram_we    = (state == st_exe) & is_store;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_val;

    assign rf_we   = (state == st_wb) & gr_we;
    assign wb_data = is_load ? load_r : alu_r;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// ==== files.f ====
common/cpu_pkg.sv
src/alu.sv
src/regfile.sv
core/decoder.sv
core/mycpu_top.sv
test/tb_mycpu_assertions.sv
test/tb_mycpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mycpu -f files.f -Mdir "$obj_dir" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"$obj_dir/sim_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log_file"; then
    exit 0
else
    echo "pass line not found in $log_file"
    exit 1
fi

// ==== src/alu.sv ====
module alu
    import cpu_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    word_t      sum;
    word_t      diff;
    word_t      slt_res;
    word_t      sltu_res;
    word_t      sll_res;
    word_t      srl_res;
    word_t      sra_res;
    logic [4:0] sa;

    assign sa = src2[4:0];

    // shared adder for add, addi, address and link values.
    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    assign slt_res  = {31'd0, $signed(src1) < $signed(src2)};
    assign sltu_res = {31'd0, src1 < src2};

    assign sll_res = src1 << sa;
    assign srl_res = src1 >> sa;
    assign sra_res = word_t'($signed(src1) >>> sa);

    always_comb begin
        result = ({32{alu_op[alu_add]}}  & sum)
               | ({32{alu_op[alu_sub]}}  & diff)
               | ({32{alu_op[alu_slt]}}  & slt_res)
               | ({32{alu_op[alu_sltu]}} & sltu_res)
               | ({32{alu_op[alu_and]}}  & (src1 & src2))
               | ({32{alu_op[alu_nor]}}  & ~(src1 | src2))
               | ({32{alu_op[alu_or]}}   & (src1 | src2))
               | ({32{alu_op[alu_xor]}}  & (src1 ^ src2))
               | ({32{alu_op[alu_sll]}}  & sll_res)
               | ({32{alu_op[alu_srl]}}  & srl_res)
               | ({32{alu_op[alu_sra]}}  & sra_res)
               | ({32{alu_op[alu_lui]}}  & src2);
    end

endmodule

// ==== src/regfile.sv ====
module regfile
    import cpu_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [32];

    // r0 is never stored.
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== test/tb_mycpu.sv ====
module tb_mycpu
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      reset;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata;
    logic      data_sram_we;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    word_t imem [64];
    word_t dmem [64];
    word_t imem_addr_q;
    word_t dmem_addr_q;

    word_t     program_q[$];
    word_t     exp_pc[$];
    reg_addr_t exp_wnum[$];
    word_t     exp_wdata[$];
    word_t     exp_st_addr[$];
    word_t     exp_st_data[$];

    int stores_seen;
    int cycles;
    int cycle_limit;
    int entry;

    mycpu_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction encodings.
    ////////////////////////////////////////////////////////////////////////////

    // also used for the shifts, with the amount in the rk field.
    function automatic word_t three_reg(logic [16:0] op, reg_addr_t rd, reg_addr_t rj,
                                       reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t imm12_form(logic [9:0] op, reg_addr_t rd, reg_addr_t rj,
                                         logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic word_t upper20(reg_addr_t rd, logic [19:0] si20);
        return {op_lu12i_w, si20, rd};
    endfunction

    // offsets count words.
    function automatic word_t off16_form(logic [5:0] op, reg_addr_t rd, reg_addr_t rj,
                                         logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t off26_form(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // program and expected results.
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_program();
        program_q.push_back(upper20(5'd4, 20'h12345));
        program_q.push_back(imm12_form(op_addi_w, 5'd4, 5'd4, 12'h678));
        program_q.push_back(imm12_form(op_addi_w, 5'd5, 5'd0, 12'hffd));
        program_q.push_back(upper20(5'd6, 20'h80000));
        program_q.push_back(imm12_form(op_addi_w, 5'd7, 5'd0, 12'h7ff));
        program_q.push_back(three_reg(op_add_w, 5'd8, 5'd4, 5'd5));
        program_q.push_back(three_reg(op_sub_w, 5'd9, 5'd5, 5'd4));
        program_q.push_back(three_reg(op_slt, 5'd10, 5'd5, 5'd4));
        program_q.push_back(three_reg(op_sltu, 5'd11, 5'd5, 5'd4));
        program_q.push_back(three_reg(op_sltu, 5'd12, 5'd4, 5'd6));
        program_q.push_back(three_reg(op_and, 5'd13, 5'd4, 5'd7));
        program_q.push_back(three_reg(op_or, 5'd14, 5'd4, 5'd6));
        program_q.push_back(three_reg(op_nor, 5'd15, 5'd4, 5'd5));
        program_q.push_back(three_reg(op_xor, 5'd16, 5'd4, 5'd5));
        program_q.push_back(three_reg(op_slli_w, 5'd17, 5'd4, 5'd4));
        program_q.push_back(three_reg(op_srli_w, 5'd18, 5'd6, 5'd4));
        program_q.push_back(three_reg(op_srai_w, 5'd19, 5'd6, 5'd4));
        program_q.push_back(three_reg(op_srai_w, 5'd20, 5'd5, 5'd1));
        // memory, base 0x40 in r21.
        program_q.push_back(imm12_form(op_addi_w, 5'd21, 5'd0, 12'h040));
        program_q.push_back(imm12_form(op_st_w, 5'd4, 5'd21, 12'h008));
        program_q.push_back(imm12_form(op_st_w, 5'd5, 5'd21, 12'hffc));
        program_q.push_back(imm12_form(op_ld_w, 5'd22, 5'd21, 12'h008));
        program_q.push_back(imm12_form(op_ld_w, 5'd23, 5'd21, 12'hffc));
        program_q.push_back(imm12_form(op_ld_w, 5'd24, 5'd21, 12'h010));
        // branches; every skipped slot writes r25.
        program_q.push_back(off16_form(op_beq, 5'd4, 5'd22, 16'd2));   // 24, taken.
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h001));
        program_q.push_back(off16_form(op_bne, 5'd4, 5'd22, 16'd2));   // 26, not taken.
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h011));
        program_q.push_back(off16_form(op_bne, 5'd4, 5'd5, 16'd2));    // 28, taken.
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h002));
        program_q.push_back(off16_form(op_beq, 5'd4, 5'd5, 16'd2));    // 30, not taken.
        program_q.push_back(off26_form(op_b, 26'd2));
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h003));
        program_q.push_back(imm12_form(op_addi_w, 5'd26, 5'd0, 12'h022));
        program_q.push_back(off26_form(op_bl, 26'd3));                  // 34, to 37.
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h004));
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h005));
        program_q.push_back(off16_form(op_jirl, 5'd27, 5'd1, 16'd4));  // 37, to 39.
        program_q.push_back(imm12_form(op_addi_w, 5'd25, 5'd0, 12'h006));
        program_q.push_back(imm12_form(op_addi_w, 5'd28, 5'd0, 12'h033));
        // r0 stays zero.
        program_q.push_back(imm12_form(op_addi_w, 5'd0, 5'd0, 12'h055));
        program_q.push_back(three_reg(op_add_w, 5'd29, 5'd0, 5'd4));
        program_q.push_back(three_reg(op_or, 5'd30, 5'd25, 5'd0));
    endtask

    task automatic expect_wb(int idx, reg_addr_t wnum, word_t wdata);
        exp_pc.push_back(reset_pc + 32'(idx * 4));
        exp_wnum.push_back(wnum);
        exp_wdata.push_back(wdata);
    endtask

    task automatic load_expected();
        expect_wb(0, 5'd4, 32'h1234_5000);
        expect_wb(1, 5'd4, 32'h1234_5678);
        expect_wb(2, 5'd5, 32'hffff_fffd);
        expect_wb(3, 5'd6, 32'h8000_0000);
        expect_wb(4, 5'd7, 32'h0000_07ff);
        expect_wb(5, 5'd8, 32'h1234_5675);
        expect_wb(6, 5'd9, 32'hedcb_a985);
        expect_wb(7, 5'd10, 32'h0000_0001);
        expect_wb(8, 5'd11, 32'h0000_0000);
        expect_wb(9, 5'd12, 32'h0000_0001);
        expect_wb(10, 5'd13, 32'h0000_0678);
        expect_wb(11, 5'd14, 32'h9234_5678);
        expect_wb(12, 5'd15, 32'h0000_0002);
        expect_wb(13, 5'd16, 32'hedcb_a985);
        expect_wb(14, 5'd17, 32'h2345_6780);
        expect_wb(15, 5'd18, 32'h0800_0000);
        expect_wb(16, 5'd19, 32'hf800_0000);
        expect_wb(17, 5'd20, 32'hffff_fffe);
        expect_wb(18, 5'd21, 32'h0000_0040);
        expect_wb(21, 5'd22, 32'h1234_5678);
        expect_wb(22, 5'd23, 32'hffff_fffd);
        expect_wb(23, 5'd24, 32'hd0d0_0050);
        expect_wb(27, 5'd25, 32'h0000_0011);
        expect_wb(33, 5'd26, 32'h0000_0022);
        expect_wb(34, 5'd1, 32'h1c00_008c);
        expect_wb(37, 5'd27, 32'h1c00_0098);
        expect_wb(39, 5'd28, 32'h0000_0033);
        expect_wb(40, 5'd0, 32'h0000_0055);
        expect_wb(41, 5'd29, 32'h1234_5678);
        expect_wb(42, 5'd30, 32'h0000_0011);
        exp_st_addr.push_back(32'h0000_0048);
        exp_st_data.push_back(32'h1234_5678);
        exp_st_addr.push_back(32'h0000_003c);
        exp_st_data.push_back(32'hffff_fffd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg(string name, reg_addr_t expected, reg_addr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sram models, one cycle read latency.
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t fetch_word(word_t addr);
        word_t offset;
        offset = addr - reset_pc;
        if (offset < 32'd256) begin
            return imem[offset[7:2]];
        end
        return 32'h0;
    endfunction

    always @(posedge clk) begin
        imem_addr_q = inst_sram_addr;
        dmem_addr_q = data_sram_addr;
        if (data_sram_we === 1'b1) begin
            dmem[data_sram_addr[7:2]] = data_sram_wdata;
        end
        #1;
        inst_sram_rdata = fetch_word(imem_addr_q);
        data_sram_rdata = dmem[dmem_addr_q[7:2]];
    end

    always @(negedge clk) begin
        if (reset === 1'b0 && data_sram_we === 1'b1) begin
            if (stores_seen >= exp_st_addr.size()) begin
                $display("unexpected store to %h at %0t", data_sram_addr, $time);
                abort_run();
            end
            check_word("data_sram_addr", exp_st_addr[stores_seen], data_sram_addr);
            check_word("data_sram_wdata", exp_st_data[stores_seen], data_sram_wdata);
            stores_seen++;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout at %0t: the writeback trace did not finish in %0d cycles",
                     $time, cycle_limit);
            abort_run();
        end
    end

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        imem_addr_q     = '0;
        dmem_addr_q     = '0;
        stores_seen     = 0;
        cycles          = 0;
        load_program();
        load_expected();
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < program_q.size()) ? program_q[i] : 32'h0;
            dmem[i] = 32'hd0d0_0000 | 32'(i * 4);
        end
        cycle_limit = 5 * program_q.size() + 20;

        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // the first fetch goes out in the first cycle after reset.
        @(negedge clk);
        check_word("inst_sram_addr", reset_pc, inst_sram_addr);

        for (entry = 0; entry < exp_pc.size(); entry++) begin
            do begin
                @(negedge clk);
            end while (debug_wb_rf_we !== 1'b1);
            check_word("debug_wb_pc", exp_pc[entry], debug_wb_pc);
            check_reg("debug_wb_rf_wnum", exp_wnum[entry], debug_wb_rf_wnum);
            check_word("debug_wb_rf_wdata", exp_wdata[entry], debug_wb_rf_wdata);
        end

        if (stores_seen != exp_st_addr.size()) begin
            $display("only %0d of %0d expected stores reached the data sram",
                     stores_seen, exp_st_addr.size());
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== test/tb_mycpu_assertions.sv ====
module tb_mycpu_assertions
    import cpu_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input cpu_state_e state,
    input logic       data_sram_we,
    input logic       debug_wb_rf_we
);

    timeunit 1ns;
    timeprecision 1ps;

    // legal successors of each fsm state.
    function automatic logic step_ok(cpu_state_e prev, cpu_state_e cur);
        logic ok;
        ok = 1'b0;
        if (prev == st_if)  ok = (cur == st_id);
        if (prev == st_id)  ok = (cur == st_if) || (cur == st_exe);
        if (prev == st_exe) ok = (cur == st_mem) || (cur == st_wb);
        if (prev == st_mem) ok = (cur == st_wb) || (cur == st_if);
        if (prev == st_wb)  ok = (cur == st_if);
        return ok;
    endfunction

    state_steps: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> step_ok($past(state), state)
    ) else $error("illegal state step from %0d to %0d", $past(state), state);

    // a store is issued in st_exe and always moves on to st_mem.
    store_in_exe: assert property (
        @(posedge clk) disable iff (reset)
        $past(data_sram_we) |-> $past(state) == st_exe && state == st_mem
    ) else $error("data_sram_we not in st_exe or not followed by st_mem, state %0d", state);

    // the trace strobe comes from st_wb and lasts a single cycle.
    trace_in_wb: assert property (
        @(posedge clk) disable iff (reset)
        $past(debug_wb_rf_we) |-> $past(state) == st_wb && !debug_wb_rf_we
    ) else $error("debug_wb_rf_we not a single pulse from st_wb, state %0d", state);

    quiet_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !data_sram_we && !debug_wb_rf_we
    ) else $error("write strobe high while reset is held");

endmodule

bind mycpu_top tb_mycpu_assertions u_assertions (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);
